// File: fb_pkg.sv
// ##################################################
// framebuffer geometry, widths and typedefs
// fixed 16 entry palette and writer FSM states
// ##################################################

package fb_pkg;

    // buffer geometry
    localparam int fb_width  = 16;                   // pixels per line
    localparam int fb_height = 12;                   // lines per buffer
    localparam int fb_pixels = fb_width * fb_height; // 192 per half

    // widths
    localparam int cord_w = 8;  // signed coordinate
    localparam int cidx_w = 4;  // colour index
    localparam int chan_w = 4;  // one rgb channel
    localparam int addr_w = 8;  // address inside one half

    typedef logic signed [cord_w-1:0] coord_t;  // pixel coordinate
    typedef logic [cidx_w-1:0]        cidx_t;   // colour index
    typedef logic [addr_w-1:0]        addr_t;   // y * fb_width + x
    typedef logic [3*chan_w-1:0]      rgb_t;    // red hi, green, blue lo
    typedef logic [addr_w:0]          phys_t;   // address across both halves

    // start of the upper half in the memory
    localparam phys_t half_ofs = phys_t'(fb_pixels);

    // fixed colour lookup, index to 4:4:4 rgb
    localparam rgb_t palette [16] = '{
        12'h000,  // 0 black
        12'h123,  // 1 dark blue
        12'h725,  // 2 purple
        12'h075,  // 3 dark green
        12'hA53,  // 4 brown
        12'h555,  // 5 dark grey
        12'hCCC,  // 6 light grey
        12'hFFF,  // 7 white
        12'hF04,  // 8 red
        12'hFA0,  // 9 orange
        12'hFE2,  // 10 yellow
        12'h0E3,  // 11 green
        12'h3AF,  // 12 sky blue
        12'h879,  // 13 lavender
        12'hF7A,  // 14 pink
        12'hFCA   // 15 peach
    };

    // pixel writer states
    typedef enum logic [1:0] {
        idle,         // after reset until first swap
        clear_sweep,  // filling back half with bgidx
        active        // accepting draw requests
    } wr_state_t;

endpackage

// File: fb_read_if.sv
// ##################################################
// read port between scan engine and memory
// ##################################################

interface fb_read_if;
    import fb_pkg::*;

    logic  rd_en;     // read strobe
    addr_t rd_addr;   // pixel address in front half
    cidx_t rd_data;   // index one cycle after rd_en
    logic  rd_valid;  // rd_en delayed by one

    // scan engine side
    modport reader (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    // memory side
    modport mem (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

// File: fb_pixel_writer.sv
// ##################################################
// pixel write engine with coordinate clipping
// two stage address pipeline and clear sweep FSM
// ##################################################

module fb_pixel_writer (
    input  logic           clk_sys,    // system clock
    input  logic           rst_sys,    // sync reset
    input  logic           we,         // draw request
    input  fb_pkg::coord_t x,          // signed column
    input  fb_pkg::coord_t y,          // signed line
    input  fb_pkg::cidx_t  cidx,       // draw colour
    input  fb_pkg::cidx_t  bgidx,      // background for clear
    input  logic           clear,      // sweep back half on swap
    input  logic           swap_done,  // swap committed pulse
    output logic           wready,     // draw accepted when high
    output logic           clip,       // last accepted write was outside
    output logic           mem_we,     // write strobe to back half
    output fb_pkg::addr_t  mem_addr,   // write address
    output fb_pkg::cidx_t  mem_data    // write index
);
    import fb_pkg::*;

    wr_state_t state;       // writer FSM
    addr_t     sweep_cnt;   // clear address
    logic      accept;      // we taken this cycle
    logic      outside;     // coordinates off the buffer
    logic      acc_p1;      // accept after stage 1
    addr_t     line_base;   // y * fb_width
    addr_t     x_off;       // x held for stage 2
    cidx_t     cidx_p1;     // colour held for stage 2
    logic      sweep_last;  // final clear address

    always_comb wready = (state == active);  // low in idle and sweep
    always_comb accept = we && wready;       // we alone is ignored

    always_comb begin
        outside = (x < 0) || (y < 0) ||
                  (x >= fb_width) || (y >= fb_height);
    end

    always_comb sweep_last = (sweep_cnt == addr_t'(fb_pixels - 1));

    // state machine
    always_ff @(posedge clk_sys) begin
        case (state)
            idle: begin
                if (swap_done) state <= clear ? clear_sweep : active;  // first swap
            end
            clear_sweep: begin
                if (sweep_last) state <= active;  // whole half written
            end
            active: begin
                if (swap_done && clear) state <= clear_sweep;
            end
            default: state <= idle;
        endcase
        if (rst_sys) state <= idle;
    end

    // clear address walks 0 to 191
    always_ff @(posedge clk_sys) begin
        if (state == clear_sweep) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end else begin
            sweep_cnt <= '0;  // ready for next sweep
        end
        if (rst_sys) sweep_cnt <= '0;
    end

    // stage 1: line base and clip decision
    always_ff @(posedge clk_sys) begin
        line_base <= addr_t'(int'(y) * fb_width);  // only meaningful in range
        x_off     <= addr_t'(x);
        cidx_p1   <= cidx;
        acc_p1    <= accept;
        clip      <= accept && outside;  // one cycle after accept
        if (rst_sys) begin
            acc_p1 <= 1'b0;
            clip   <= 1'b0;
        end
    end

    // stage 2: final address, sweep takes priority
    always_ff @(posedge clk_sys) begin
        if (state == clear_sweep) begin
            mem_addr <= sweep_cnt;
            mem_data <= bgidx;
        end else begin
            mem_addr <= line_base + x_off;
            mem_data <= cidx_p1;
        end
        mem_we <= (state == clear_sweep) || (acc_p1 && !clip);  // clipped writes dropped
        if (rst_sys) mem_we <= 1'b0;
    end

endmodule

// File: fb_scan_reader.sv
// ##################################################
// raster scan engine for the front buffer
// palette lookup and blanked rgb output
// ##################################################

module fb_scan_reader (
    input  logic                     clk_sys,    // system clock
    input  logic                     rst_sys,    // sync reset
    input  logic                     frame,      // frame start pulse
    input  logic                     de,         // display enable
    output logic                     rgb_valid,  // de delayed by three
    output logic [fb_pkg::chan_w-1:0] red,       // red channel
    output logic [fb_pkg::chan_w-1:0] green,     // green channel
    output logic [fb_pkg::chan_w-1:0] blue,      // blue channel
    fb_read_if.reader                rd          // read port to memory
);
    import fb_pkg::*;

    addr_t rd_ptr;    // next pixel to fetch
    addr_t ptr_base;  // pointer after frame restart
    addr_t ptr_next;  // pointer after this read
    rgb_t  rgb_q;     // palette output register

    // frame restarts the raster at pixel 0
    always_comb ptr_base = frame ? '0 : rd_ptr;

    // wrap after the last pixel of the buffer
    always_comb begin
        if (ptr_base == addr_t'(fb_pixels - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = ptr_base + 1'b1;
        end
    end

    // pointer register
    always_ff @(posedge clk_sys) begin
        if (de) begin
            rd_ptr <= ptr_next;  // one pixel per de
        end else begin
            rd_ptr <= ptr_base;  // hold or restart
        end
        if (rst_sys) rd_ptr <= '0;
    end

    // read request, latency cycle 1
    always_ff @(posedge clk_sys) begin
        rd.rd_addr <= ptr_base;
        rd.rd_en   <= de;
        if (rst_sys) rd.rd_en <= 1'b0;
    end

    // memory returns index in cycle 2, palette registered in cycle 3
    always_ff @(posedge clk_sys) begin
        rgb_q     <= palette[rd.rd_data];
        rgb_valid <= rd.rd_valid;
        if (rst_sys) rgb_valid <= 1'b0;
    end

    // outputs forced to black outside valid
    always_comb begin
        red   = rgb_valid ? rgb_q[2*chan_w +: chan_w] : '0;
        green = rgb_valid ? rgb_q[chan_w +: chan_w] : '0;
        blue  = rgb_valid ? rgb_q[0 +: chan_w] : '0;
    end

endmodule

// File: fb_double_buffer.sv
// ##################################################
// two half framebuffer memory with front/back select
// four phase swap handshake on frame start
// ##################################################

module fb_double_buffer (
    input  logic          clk_sys,    // system clock
    input  logic          rst_sys,    // sync reset
    input  logic          frame,      // frame start pulse
    input  logic          swap_req,   // client swap request
    input  logic          mem_we,     // write strobe from writer
    input  fb_pkg::addr_t mem_addr,   // write address in back half
    input  fb_pkg::cidx_t mem_data,   // write index
    output logic          swap_ack,   // handshake acknowledge
    output logic          swap_done,  // one cycle at commit
    fb_read_if.mem        rd          // read port from scanner
);
    import fb_pkg::*;

    cidx_t ram [2*fb_pixels];  // both halves, 384 entries
    logic  front_sel;          // half shown by the scanner
    logic  commit;             // swap taken this cycle
    phys_t wr_phys;            // back half address
    phys_t rd_phys;            // front half address

    // half 0 sits at 0 and half 1 at half_ofs
    always_comb begin
        wr_phys = phys_t'(mem_addr) + (front_sel ? '0 : half_ofs);  // back
        rd_phys = phys_t'(rd.rd_addr) + (front_sel ? half_ofs : '0);  // front
    end

    // writes land in the back half
    always_ff @(posedge clk_sys) begin
        if (mem_we) ram[wr_phys] <= mem_data;
    end

    // registered read from the front half
    always_ff @(posedge clk_sys) begin
        if (rd.rd_en) rd.rd_data <= ram[rd_phys];
    end

    always_ff @(posedge clk_sys) begin
        rd.rd_valid <= rd.rd_en;  // data valid one cycle later
        if (rst_sys) rd.rd_valid <= 1'b0;
    end

    // pending request only honoured at a frame start
    always_comb commit = frame && swap_req && !swap_ack;

    // handshake and buffer select
    always_ff @(posedge clk_sys) begin
        swap_done <= commit;
        if (commit) begin
            front_sel <= ~front_sel;  // back becomes front
            swap_ack  <= 1'b1;
        end else if (swap_ack && !swap_req) begin
            swap_ack <= 1'b0;  // request withdrawn
        end
        if (rst_sys) begin
            front_sel <= 1'b0;  // half 0 shown after reset
            swap_ack  <= 1'b0;
            swap_done <= 1'b0;
        end
    end

endmodule

// File: framebuffer_top.sv
// ##################################################
// framebuffer top level
// writer, scanner and double buffer memory
// ##################################################

module framebuffer_top (
    input  logic                      clk_sys,    // system clock
    input  logic                      rst_sys,    // sync reset
    input  logic                      frame,      // frame start pulse
    input  logic                      de,         // display enable
    input  logic                      we,         // draw request
    input  fb_pkg::coord_t            x,          // signed column
    input  fb_pkg::coord_t            y,          // signed line
    input  fb_pkg::cidx_t             cidx,       // draw colour
    input  fb_pkg::cidx_t             bgidx,      // clear colour
    input  logic                      clear,      // clear back half on swap
    input  logic                      swap_req,   // swap request
    output logic                      wready,     // writer ready
    output logic                      clip,       // write was off buffer
    output logic                      swap_ack,   // swap acknowledge
    output logic                      rgb_valid,  // pixel output valid
    output logic [fb_pkg::chan_w-1:0] red,        // red channel
    output logic [fb_pkg::chan_w-1:0] green,      // green channel
    output logic [fb_pkg::chan_w-1:0] blue        // blue channel
);
    import fb_pkg::*;

    logic  mem_we;     // writer strobe
    addr_t mem_addr;   // writer address
    cidx_t mem_data;   // writer index
    logic  swap_done;  // swap commit pulse

    fb_read_if rd_bus ();  // scanner to memory

    fb_pixel_writer writer_i (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .we        (we),
        .x         (x),
        .y         (y),
        .cidx      (cidx),
        .bgidx     (bgidx),
        .clear     (clear),
        .swap_done (swap_done),
        .wready    (wready),
        .clip      (clip),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data)
    );

    fb_scan_reader scanner_i (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .frame     (frame),
        .de        (de),
        .rgb_valid (rgb_valid),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .rd        (rd_bus.reader)
    );

    fb_double_buffer buffer_i (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .frame     (frame),
        .swap_req  (swap_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .swap_ack  (swap_ack),
        .swap_done (swap_done),
        .rd        (rd_bus.mem)
    );

endmodule

// File: tb_framebuffer.sv
// ##################################################
// testbench for the framebuffer top level
// seeded random draws, reference model, scan checks
// ##################################################

module tb_framebuffer;
    timeunit 1ns;
    timeprecision 1ps;
    import fb_pkg::*;

    localparam int wait_max = 400;   // cycle limit for handshake waits
    localparam int scan_max = 3000;  // cycle limit for one scanned frame

    logic              clk_sys;    // 40 ns clock
    logic              rst_sys;    // sync reset
    logic              frame;      // frame start pulse
    logic              de;         // display enable
    logic              we;         // draw request
    coord_t            x;          // draw column
    coord_t            y;          // draw line
    cidx_t             cidx;       // draw colour
    cidx_t             bgidx;      // clear colour
    logic              clear;      // clear on swap
    logic              swap_req;   // swap request
    logic              wready;
    logic              clip;
    logic              swap_ack;
    logic              rgb_valid;
    logic [chan_w-1:0] red;
    logic [chan_w-1:0] green;
    logic [chan_w-1:0] blue;

    cidx_t model_mem [2][fb_pixels];  // reference copy of both halves
    int    front;                     // model front half
    int    errors;                    // all failures so far
    int    err_mark;                  // errors at test start
    int    tests_run;
    int    tests_failed;
    string test_name;
    cidx_t bg;                        // background for current test
    int    n;                         // wait counter in main flow

    framebuffer_top dut_i (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .frame     (frame),
        .de        (de),
        .we        (we),
        .x         (x),
        .y         (y),
        .cidx      (cidx),
        .bgidx     (bgidx),
        .clear     (clear),
        .swap_req  (swap_req),
        .wready    (wready),
        .clip      (clip),
        .swap_ack  (swap_ack),
        .rgb_valid (rgb_valid),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial clk_sys = 1'b0;
    always #20 clk_sys = ~clk_sys;  // 40 ns period

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    // stimulus and sampling both happen 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    task automatic check_idle_outputs(input string phase);
        if (wready !== 1'b0) begin
            $display("[FAIL] %s: wready %s expected 0 actual %b", test_name, phase, wready);
            errors++;
        end
        if (swap_ack !== 1'b0) begin
            $display("[FAIL] %s: swap_ack %s expected 0 actual %b", test_name, phase, swap_ack);
            errors++;
        end
        if (rgb_valid !== 1'b0) begin
            $display("[FAIL] %s: rgb_valid %s expected 0 actual %b", test_name, phase,
                     rgb_valid);
            errors++;
        end
        if ({red, green, blue} !== 12'h000) begin
            $display("[FAIL] %s: rgb %s expected 000 actual %h", test_name, phase,
                     {red, green, blue});
            errors++;
        end
    endtask

    task automatic wait_wready();
        int cnt;
        cnt = 0;
        while (wready !== 1'b1 && cnt < wait_max) begin
            next_cycle();
            cnt++;
        end
        if (wready !== 1'b1) begin
            $display("error in %s: wready did not rise within %0d cycles", test_name, wait_max);
            errors++;
        end
    endtask

    // one draw, clip checked a cycle after acceptance
    task automatic draw_pixel(input coord_t px, input coord_t py, input cidx_t pc);
        logic exp_clip;
        exp_clip = (int'(px) < 0) || (int'(py) < 0) ||
                   (int'(px) >= fb_width) || (int'(py) >= fb_height);
        wait_wready();
        we   = 1'b1;
        x    = px;
        y    = py;
        cidx = pc;
        next_cycle();  // accepting edge
        we = 1'b0;
        if (clip !== exp_clip) begin
            $display("[FAIL] %s: clip at (%0d,%0d) expected %b actual %b", test_name,
                     px, py, exp_clip, clip);
            errors++;
        end
        if (!exp_clip) model_mem[front ^ 1][int'(py) * fb_width + int'(px)] = pc;
    endtask

    // four phase swap, optional clear of the new back half
    task automatic swap_buffers(input logic clr, input cidx_t bgv);
        int cnt;
        int i;
        repeat (3) next_cycle();  // pending writes land first
        swap_req = 1'b1;
        clear    = clr;
        bgidx    = bgv;
        repeat (3) begin
            next_cycle();
            if (swap_ack !== 1'b0) begin
                $display("[FAIL] %s: swap_ack before frame expected 0 actual %b",
                         test_name, swap_ack);
                errors++;
            end
        end
        frame = 1'b1;
        next_cycle();
        frame = 1'b0;
        cnt = 0;
        while (swap_ack !== 1'b1 && cnt < wait_max) begin
            next_cycle();
            cnt++;
        end
        if (swap_ack !== 1'b1) begin
            $display("error in %s: swap_ack did not rise after frame", test_name);
            errors++;
        end
        swap_req = 1'b0;
        cnt = 0;
        while (swap_ack !== 1'b0 && cnt < wait_max) begin
            next_cycle();
            cnt++;
        end
        if (swap_ack !== 1'b0) begin
            $display("error in %s: swap_ack stayed high after swap_req fell", test_name);
            errors++;
        end
        clear = 1'b0;
        front = front ^ 1;  // model flip
        if (clr) begin
            for (i = 0; i < fb_pixels; i++) model_mem[front ^ 1][i] = bgv;
        end
    endtask

    // full frame with random gaps in de, compared in raster order
    task automatic scan_frame();
        int         issued;
        int         seen;
        int         tail;
        int         cnt;
        rgb_t       exp_rgb;
        rgb_t       act_rgb;
        logic [2:0] de_hist;  // de of the last three driven cycles
        issued  = 0;
        seen    = 0;
        tail    = 0;
        cnt     = 0;
        de_hist = '0;
        frame   = 1'b1;  // pointer back to pixel 0
        next_cycle();
        frame = 1'b0;
        while (cnt < scan_max && (issued < fb_pixels || tail < 5)) begin
            act_rgb = {red, green, blue};
            if (rgb_valid !== de_hist[2]) begin
                $display("[FAIL] %s: rgb_valid three cycles after de expected %b actual %b",
                         test_name, de_hist[2], rgb_valid);
                errors++;
            end
            if (rgb_valid === 1'b1) begin
                if (seen < fb_pixels) begin
                    exp_rgb = palette[model_mem[front][seen]];
                    if (act_rgb !== exp_rgb) begin
                        $display("[FAIL] %s: pixel %0d expected %h actual %h", test_name,
                                 seen, exp_rgb, act_rgb);
                        errors++;
                    end
                end
                seen++;
            end else if (act_rgb !== 12'h000) begin
                $display("[FAIL] %s: rgb while invalid expected 000 actual %h", test_name,
                         act_rgb);
                errors++;
            end
            if (issued < fb_pixels) begin
                de = ($urandom_range(0, 3) != 0);  // about one gap in four
                if (de) issued++;
            end else begin
                de = 1'b0;
                tail++;  // drain the three stage latency
            end
            de_hist = {de_hist[1:0], de};
            next_cycle();
            cnt++;
        end
        de = 1'b0;
        if (issued < fb_pixels || tail < 5) begin
            $display("error in %s: scan did not finish within %0d cycles", test_name, scan_max);
            errors++;
        end
        if (seen != fb_pixels) begin
            $display("[FAIL] %s: valid pixel count expected %0d actual %0d", test_name,
                     fb_pixels, seen);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(57464));
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        front        = 0;
        rst_sys      = 1'b1;
        frame        = 1'b0;
        de           = 1'b0;
        we           = 1'b0;
        x            = '0;
        y            = '0;
        cidx         = '0;
        bgidx        = '0;
        clear        = 1'b0;
        swap_req     = 1'b0;

        start_test("reset_state");
        repeat (5) next_cycle();
        check_idle_outputs("during reset");
        repeat (5) next_cycle();
        rst_sys = 1'b0;  // released after 10 edges
        next_cycle();
        check_idle_outputs("after reset");
        end_test();

        start_test("swap_with_clear");
        swap_buffers(1'b1, cidx_t'($urandom_range(0, 15)));
        wait_wready();  // sweep done
        end_test();

        start_test("random_draw_scan");
        repeat (150) begin
            draw_pixel(coord_t'($urandom_range(0, fb_width - 1)),
                       coord_t'($urandom_range(0, fb_height - 1)),
                       cidx_t'($urandom_range(0, 15)));
        end
        swap_buffers(1'b0, '0);
        scan_frame();
        end_test();

        start_test("clipping");
        swap_buffers(1'b1, cidx_t'($urandom_range(0, 15)));
        wait_wready();
        repeat (60) begin
            if ($urandom_range(0, 3) == 0) begin
                draw_pixel(coord_t'($urandom_range(0, fb_width - 1)),
                           coord_t'($urandom_range(0, fb_height - 1)),
                           cidx_t'($urandom_range(0, 15)));
            end else begin
                draw_pixel(coord_t'($urandom), coord_t'($urandom),
                           cidx_t'($urandom_range(0, 15)));  // mostly off buffer
            end
        end
        swap_buffers(1'b0, '0);
        scan_frame();
        end_test();

        start_test("clear_to_background");
        bg = cidx_t'($urandom_range(0, 15));
        swap_buffers(1'b1, bg);
        wait_wready();
        swap_buffers(1'b0, '0);
        scan_frame();
        end_test();

        start_test("back_pressure");
        bg = cidx_t'($urandom_range(0, 15));
        swap_buffers(1'b1, bg);
        if (wready !== 1'b0) begin
            $display("[FAIL] %s: wready in sweep expected 0 actual %b", test_name, wready);
            errors++;
        end
        we = 1'b1;  // held while the sweep runs
        n  = 0;
        while (wready !== 1'b1 && n < wait_max) begin
            x    = coord_t'($urandom_range(0, fb_width - 1));
            y    = coord_t'($urandom_range(0, fb_height - 1));
            cidx = ~bg;
            next_cycle();
            n++;
        end
        we = 1'b0;  // dropped before the first ready edge
        if (wready !== 1'b1) begin
            $display("error in %s: wready did not rise after the sweep", test_name);
            errors++;
        end
        swap_buffers(1'b0, '0);
        scan_frame();
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
fb_pkg.sv
fb_read_if.sv
fb_pixel_writer.sv
fb_scan_reader.sv
fb_double_buffer.sv
framebuffer_top.sv
tb_framebuffer.sv
